//--- design/rx_lbuf_pkg.sv
`default_nettype none

package rx_lbuf_pkg;

    ////////////////////////////////////////
    // widths and types
    ////////////////////////////////////////
    localparam int ADDR_W     = 64;  // host bus address
    localparam int DATA_W     = 64;  // stream and memory word
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////
    localparam apb_addr_t REG_LBUF1_LO   = 8'h00;  // slot 1 address [31:0]
    localparam apb_addr_t REG_LBUF1_HI   = 8'h04;  // slot 1 address [63:32]
    localparam apb_addr_t REG_LBUF1_CTRL = 8'h08;  // bit 0 arm / armed
    localparam apb_addr_t REG_LBUF2_LO   = 8'h0C;
    localparam apb_addr_t REG_LBUF2_HI   = 8'h10;
    localparam apb_addr_t REG_LBUF2_CTRL = 8'h14;
    localparam apb_addr_t REG_DONE_CNT   = 8'h18;  // read only, low 16 bits

    // giver walks slot 1 then slot 2 and back
    typedef enum logic [1:0] {
        GV_WAIT1,
        GV_BUSY1,
        GV_WAIT2,
        GV_BUSY2
    } gv_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_FILL,
        WR_DONE
    } wr_state_e;

endpackage

`default_nettype wire

//--- design/lbuf_if.sv
`timescale 1ns/1ns
`default_nettype none

// one lbuf grant between giver and writer
interface lbuf_if
    import rx_lbuf_pkg::*;
();

    addr_t addr;   // lbuf base, stable while en
    logic  en;     // grant held until dn
    logic  is64;   // upper address half nonzero
    logic  dn;     // one cycle, lbuf full

    modport giver (
        output addr, en, is64,
        input  dn
    );

    modport filler (
        input  addr, en, is64,
        output dn
    );

endinterface

`default_nettype wire

//--- design/rx_host_regs.sv
`timescale 1ns/1ns
`default_nettype none

module rx_host_regs
    import rx_lbuf_pkg::*;
(
    input  wire            clk,
    input  wire            rst,

    // apb slave
    input  wire            psel,
    input  wire            penable,
    input  wire            pwrite,
    input  wire apb_addr_t paddr,
    input  wire apb_data_t pwdata,
    output apb_data_t      prdata,
    output logic           pready,
    output logic           pslverr,

    // slots to the giver
    output addr_t          lbuf1_addr,
    output logic           lbuf1_en,
    input  wire            lbuf1_dn,
    output addr_t          lbuf2_addr,
    output logic           lbuf2_en,
    input  wire            lbuf2_dn
);

    addr_t       slot_addr [2];  // 64-bit base per slot
    logic [1:0]  slot_en;        // arm bits
    logic [1:0]  slot_dn;
    logic [15:0] done_cnt;       // completed lbufs, wraps

    logic        acc;            // access phase
    logic        wr_acc;
    logic        addr_ok;        // offset is in the map
    logic [1:0]  wr_lo;
    logic [1:0]  wr_hi;
    logic [1:0]  wr_arm;

    ////////////////////////////////////////
    // apb decode
    ////////////////////////////////////////
    assign acc    = psel && penable;
    assign wr_acc = acc && pwrite;
    assign pready = 1'b1;  // no wait states

    // bad offset or write to the read-only counter
    assign pslverr = acc && (!addr_ok || (pwrite && paddr == REG_DONE_CNT));

    assign wr_lo[0]  = wr_acc && paddr == REG_LBUF1_LO;
    assign wr_hi[0]  = wr_acc && paddr == REG_LBUF1_HI;
    assign wr_arm[0] = wr_acc && paddr == REG_LBUF1_CTRL && pwdata[0];
    assign wr_lo[1]  = wr_acc && paddr == REG_LBUF2_LO;
    assign wr_hi[1]  = wr_acc && paddr == REG_LBUF2_HI;
    assign wr_arm[1] = wr_acc && paddr == REG_LBUF2_CTRL && pwdata[0];

    assign slot_dn = {lbuf2_dn, lbuf1_dn};

    // read mux, also flags valid offsets
    always_comb begin
        addr_ok = 1'b1;
        case (paddr)
            REG_LBUF1_LO   : prdata = slot_addr[0][31:0];
            REG_LBUF1_HI   : prdata = slot_addr[0][63:32];
            REG_LBUF1_CTRL : prdata = apb_data_t'(slot_en[0]);
            REG_LBUF2_LO   : prdata = slot_addr[1][31:0];
            REG_LBUF2_HI   : prdata = slot_addr[1][63:32];
            REG_LBUF2_CTRL : prdata = apb_data_t'(slot_en[1]);
            REG_DONE_CNT   : prdata = apb_data_t'(done_cnt);
            default : begin
                prdata  = '0;
                addr_ok = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////
    // slot registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (wr_lo[i])
                slot_addr[i][31:0] <= pwdata;
            if (wr_hi[i])
                slot_addr[i][63:32] <= pwdata;
        end
    end

    // arm on write of 1, clear on the slot's done
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_en  <= '0;
            done_cnt <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (slot_dn[i])
                    slot_en[i] <= 1'b0;
                else if (wr_arm[i])
                    slot_en[i] <= 1'b1;  // no effect when already armed
            end
            done_cnt <= done_cnt + 16'(slot_dn[0]) + 16'(slot_dn[1]);
        end
    end

    // out to the giver
    assign lbuf1_addr = slot_addr[0];
    assign lbuf1_en   = slot_en[0];
    assign lbuf2_addr = slot_addr[1];
    assign lbuf2_en   = slot_en[1];

endmodule

`default_nettype wire

//--- design/rx_gv_lbuf.sv
`timescale 1ns/1ns
`default_nettype none

module rx_gv_lbuf
    import rx_lbuf_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    // slots from the register block
    input  wire addr_t  lbuf1_addr,
    input  wire         lbuf1_en,
    output logic        lbuf1_dn,
    input  wire addr_t  lbuf2_addr,
    input  wire         lbuf2_en,
    output logic        lbuf2_dn,

    lbuf_if.giver       gv
);

    gv_state_e state;

    ////////////////////////////////////////
    // grant fsm
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= GV_WAIT1;
            gv.en    <= 1'b0;
            lbuf1_dn <= 1'b0;
            lbuf2_dn <= 1'b0;
        end else begin
            lbuf1_dn <= 1'b0;  // single cycle pulses
            lbuf2_dn <= 1'b0;
            case (state)
                GV_WAIT1 : begin
                    if (lbuf1_en) begin  // slot 2 armed early just waits
                        gv.en <= 1'b1;
                        state <= GV_BUSY1;
                    end
                end
                GV_BUSY1 : begin
                    if (gv.dn) begin
                        gv.en    <= 1'b0;
                        lbuf1_dn <= 1'b1;
                        state    <= GV_WAIT2;
                    end
                end
                GV_WAIT2 : begin
                    if (lbuf2_en) begin
                        gv.en <= 1'b1;
                        state <= GV_BUSY2;
                    end
                end
                GV_BUSY2 : begin
                    if (gv.dn) begin
                        gv.en    <= 1'b0;
                        lbuf2_dn <= 1'b1;
                        state    <= GV_WAIT1;  // back to slot 1
                    end
                end
                default : state <= GV_WAIT1;
            endcase
        end
    end

    // address tracks the waiting slot, frozen while busy
    always_ff @(posedge clk) begin
        if (state == GV_WAIT1) begin
            gv.addr <= lbuf1_addr;
            gv.is64 <= |lbuf1_addr[63:32];
        end else if (state == GV_WAIT2) begin
            gv.addr <= lbuf2_addr;
            gv.is64 <= |lbuf2_addr[63:32];
        end
    end

endmodule

`default_nettype wire

//--- design/rx_lbuf_writer.sv
`timescale 1ns/1ns
`default_nettype none

module rx_lbuf_writer
    import rx_lbuf_pkg::*;
#(
    parameter int LBUF_WORDS = 16  // 64-bit words per lbuf
) (
    input  wire         clk,
    input  wire         rst,

    lbuf_if.filler      fl,

    // packet stream in
    input  wire data_t  pkt_data,
    input  wire         pkt_valid,
    output logic        pkt_ready,

    // memory write requests out
    output addr_t       mem_addr,
    output data_t       mem_data,
    output logic        mem_is64,
    output logic        mem_valid,
    input  wire         mem_ready
);

    localparam int CNT_W = $clog2(LBUF_WORDS);

    wr_state_e        state;
    logic [CNT_W-1:0] word_cnt;   // index of the next stream word
    logic             mem_last;   // pending request is the lbuf's last word
    logic             take;       // stream word accepted
    logic             mem_go;     // request accepted

    ////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////
    assign mem_go = mem_valid && mem_ready;

    // output reg free or draining, and last word not yet taken
    assign pkt_ready = (state == WR_FILL)
                       && !(mem_valid && mem_last)
                       && (!mem_valid || mem_ready);

    assign take  = pkt_valid && pkt_ready;
    assign fl.dn = (state == WR_DONE);  // one cycle in WR_DONE

    ////////////////////////////////////////
    // fill fsm
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= WR_IDLE;
            word_cnt  <= '0;
            mem_valid <= 1'b0;
        end else begin
            case (state)
                WR_IDLE : begin
                    if (fl.en) begin  // new grant
                        state    <= WR_FILL;
                        word_cnt <= '0;
                    end
                end
                WR_FILL : begin
                    if (take)
                        word_cnt <= word_cnt + 1'b1;
                    if (mem_go && mem_last)
                        state <= WR_DONE;
                end
                WR_DONE : state <= WR_IDLE;  // giver drops en meanwhile
                default : state <= WR_IDLE;
            endcase

            if (take)
                mem_valid <= 1'b1;
            else if (mem_ready)
                mem_valid <= 1'b0;
        end
    end

    // request payload, base plus 8 bytes per word
    always_ff @(posedge clk) begin
        if (take) begin
            mem_addr <= fl.addr + addr_t'({word_cnt, 3'b000});
            mem_data <= pkt_data;
            mem_is64 <= fl.is64;
            mem_last <= (word_cnt == CNT_W'(LBUF_WORDS - 1));
        end
    end

endmodule

`default_nettype wire

//--- design/rx_lbuf_top.sv
`timescale 1ns/1ns
`default_nettype none

module rx_lbuf_top
    import rx_lbuf_pkg::*;
#(
    parameter int LBUF_WORDS = 16
) (
    input  wire            clk,
    input  wire            rst,

    // host apb
    input  wire            psel,
    input  wire            penable,
    input  wire            pwrite,
    input  wire apb_addr_t paddr,
    input  wire apb_data_t pwdata,
    output apb_data_t      prdata,
    output logic           pready,
    output logic           pslverr,

    // packet stream
    input  wire data_t     pkt_data,
    input  wire            pkt_valid,
    output logic           pkt_ready,

    // memory writes
    output addr_t          mem_addr,
    output data_t          mem_data,
    output logic           mem_is64,
    output logic           mem_valid,
    input  wire            mem_ready
);

    addr_t lbuf1_addr;
    logic  lbuf1_en;
    logic  lbuf1_dn;
    addr_t lbuf2_addr;
    logic  lbuf2_en;
    logic  lbuf2_dn;

    lbuf_if gv_if ();  // giver to writer

    rx_host_regs i_rx_host_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .lbuf1_addr (lbuf1_addr),
        .lbuf1_en   (lbuf1_en),
        .lbuf1_dn   (lbuf1_dn),
        .lbuf2_addr (lbuf2_addr),
        .lbuf2_en   (lbuf2_en),
        .lbuf2_dn   (lbuf2_dn)
    );

    rx_gv_lbuf i_rx_gv_lbuf (
        .clk        (clk),
        .rst        (rst),
        .lbuf1_addr (lbuf1_addr),
        .lbuf1_en   (lbuf1_en),
        .lbuf1_dn   (lbuf1_dn),
        .lbuf2_addr (lbuf2_addr),
        .lbuf2_en   (lbuf2_en),
        .lbuf2_dn   (lbuf2_dn),
        .gv         (gv_if.giver)
    );

    rx_lbuf_writer #(
        .LBUF_WORDS (LBUF_WORDS)
    ) i_rx_lbuf_writer (
        .clk        (clk),
        .rst        (rst),
        .fl         (gv_if.filler),
        .pkt_data   (pkt_data),
        .pkt_valid  (pkt_valid),
        .pkt_ready  (pkt_ready),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .mem_is64   (mem_is64),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready)
    );

endmodule

`default_nettype wire

//--- testbench/tb_rx_lbuf.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rx_lbuf
    import rx_lbuf_pkg::*;
();

    localparam int LBUF_WORDS   = 16;
    localparam int NUM_PAIRS    = 5;     // ten lbufs over both slots
    localparam int DONE_TIMEOUT = 2000;  // cycles per lbuf
    localparam int CTRL_POLLS   = 20;
    localparam int APB_TIMEOUT  = 16;
    localparam int QUIET_CYCLES = 40;    // window with only slot 2 armed

    typedef struct packed {
        addr_t base;
        logic  is64;
    } lbuf_t;

    logic      clk;
    logic      rst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    data_t     pkt_data;
    logic      pkt_valid;
    logic      pkt_ready;
    addr_t     mem_addr;
    data_t     mem_data;
    logic      mem_is64;
    logic      mem_valid;
    logic      mem_ready;

    lbuf_t lbuf_q [$];   // expected lbufs in fill order
    data_t word_q [$];   // stream words taken by the DUT
    int    word_idx;     // word within the head lbuf
    int    lbufs_done;
    logic  pkt_fire;     // stream transfer on the coming edge

    rx_lbuf_top #(.LBUF_WORDS(LBUF_WORDS)) i_rx_lbuf_top (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_mem(input addr_t ga, input addr_t ea, input data_t gd,
                             input data_t ed, input logic gi, input logic ei);
        if (ga !== ea) begin
            $display("Fail mem_addr got %h exp %h", ga, ea);
            abort_run();
        end
        if (gd !== ed) begin
            $display("Fail mem_data got %h exp %h", gd, ed);
            abort_run();
        end
        if (gi !== ei) begin
            $display("Fail mem_is64 got %h exp %h", gi, ei);
            abort_run();
        end
    endtask

    task automatic check_apb(input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            $display("Fail prdata got %h exp %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_err(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail pslverr got %h exp %h", got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // apb master
    ////////////////////////////////////////
    task automatic apb_xfer(input logic wr, input apb_addr_t a, input apb_data_t wd,
                            output apb_data_t rd, output logic err);
        int waits;
        @(posedge clk);  // setup phase
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= a;
        pwdata  <= wd;
        @(posedge clk);  // access phase
        penable <= 1'b1;
        @(negedge clk);
        waits = 0;
        while (!pready && waits < APB_TIMEOUT) begin
            @(negedge clk);
            waits++;
        end
        if (!pready) begin
            $display("APB access to offset %h never saw pready", a);
            abort_run();
        end
        rd  = prdata;   // sampled mid cycle where stable
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t a, input apb_data_t d, input logic exp_err);
        apb_data_t rd;
        logic      err;
        apb_xfer(1'b1, a, d, rd, err);
        check_err(err, exp_err);
    endtask

    task automatic apb_read(input apb_addr_t a, output apb_data_t d, input logic exp_err);
        logic err;
        apb_xfer(1'b0, a, '0, d, err);
        check_err(err, exp_err);
    endtask

    task automatic check_readback(input apb_addr_t a);
        apb_data_t wd;
        apb_data_t rd;
        wd = $urandom;
        apb_write(a, wd, 1'b0);
        apb_read(a, rd, 1'b0);
        check_apb(rd, wd);
    endtask

    ////////////////////////////////////////
    // slot helpers and model
    ////////////////////////////////////////
    function automatic addr_t random_base(input logic zero_hi);
        logic [31:0] hi;
        hi = zero_hi ? 32'h0 : $urandom;
        if (!zero_hi && hi == 32'h0)
            hi = 32'h1;  // keep it a 64-bit address
        return {hi, 32'($urandom)};
    endfunction

    task automatic push_lbuf(input addr_t b, input logic wide);
        lbuf_t e;
        e.base = b;
        e.is64 = wide;  // known from how the base was made
        lbuf_q.push_back(e);
    endtask

    task automatic load_slot(input int s, input addr_t b);
        apb_write(s ? REG_LBUF2_LO : REG_LBUF1_LO, b[31:0], 1'b0);
        apb_write(s ? REG_LBUF2_HI : REG_LBUF1_HI, b[63:32], 1'b0);
    endtask

    task automatic arm_slot(input int s);
        apb_write(s ? REG_LBUF2_CTRL : REG_LBUF1_CTRL, 32'h1, 1'b0);
    endtask

    task automatic wait_lbufs(input int n);
        int cycles;
        cycles = 0;
        while (lbufs_done < n && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (lbufs_done < n) begin
            $display("lbuf %0d was never completed by the writer", n);
            abort_run();
        end
    endtask

    task automatic poll_ctrl_clear(input int s);
        apb_data_t d;
        int        tries;
        d     = 32'h1;
        tries = 0;
        while (d[0] && tries < CTRL_POLLS) begin
            apb_read(s ? REG_LBUF2_CTRL : REG_LBUF1_CTRL, d, 1'b0);
            tries++;
        end
        if (d[0]) begin
            $display("slot %0d stayed armed after its lbuf was written", s + 1);
            abort_run();
        end
        check_apb(d, 32'h0);
    endtask

    // nothing may move while only slot 2 is armed
    task automatic expect_quiet();
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            if (mem_valid || pkt_ready) begin
                $display("writer started before slot 1 was armed");
                abort_run();
            end
        end
    endtask

    // compares one accepted memory request against the head lbuf
    task automatic check_request();
        lbuf_t head;
        data_t exp_data;
        if (lbuf_q.size() == 0 || word_q.size() == 0) begin
            $display("memory request with no expected lbuf or no stream word");
            abort_run();
        end
        head     = lbuf_q[0];
        exp_data = word_q.pop_front();
        check_mem(mem_addr, head.base + addr_t'(8 * word_idx), mem_data, exp_data,
                  mem_is64, head.is64);
        word_idx++;
        if (word_idx == LBUF_WORDS) begin  // lbuf full
            word_idx = 0;
            lbuf_q.delete(0);
            lbufs_done++;
        end
    endtask

    ////////////////////////////////////////
    // stream source, memory sink, monitor
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            pkt_valid <= 1'b0;
            mem_ready <= 1'b0;
        end else begin
            if (!pkt_valid || pkt_fire) begin  // hold word until taken
                pkt_valid <= ($urandom % 4) != 0;
                pkt_data  <= {$urandom, $urandom};
            end
            mem_ready <= ($urandom % 3) != 0;  // random stalls
        end
    end

    always @(negedge clk) begin
        pkt_fire = !rst && pkt_valid && pkt_ready;
        if (pkt_fire)
            word_q.push_back(pkt_data);
        if (!rst && mem_valid && mem_ready)
            check_request();
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        apb_data_t rd;
        addr_t     base [2];
        logic      wide [2];
        void'($urandom(32'hc72a_922f));
        clk        = 1'b0;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pkt_data   = '0;
        pkt_valid  = 1'b0;
        mem_ready  = 1'b0;
        pkt_fire   = 1'b0;
        word_idx   = 0;
        lbufs_done = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        apb_read(REG_LBUF1_CTRL, rd, 1'b0);  // both disarmed out of reset
        check_apb(rd, 32'h0);
        apb_read(REG_LBUF2_CTRL, rd, 1'b0);
        check_apb(rd, 32'h0);
        check_readback(REG_LBUF1_LO);
        check_readback(REG_LBUF1_HI);
        check_readback(REG_LBUF2_LO);
        check_readback(REG_LBUF2_HI);

        // unmapped offset and read-only counter
        apb_read(8'h1C, rd, 1'b1);
        apb_write(REG_DONE_CNT, 32'h0000_5a5a, 1'b1);
        apb_read(REG_DONE_CNT, rd, 1'b0);
        check_apb(rd, 32'h0);

        for (int p = 0; p < NUM_PAIRS; p++) begin
            for (int s = 0; s < 2; s++) begin
                wide[s] = ((p + s) % 2) != 0;  // half zero upper
                base[s] = random_base(!wide[s]);
            end
            if (p == 0) begin
                load_slot(1, base[1]);  // slot 2 out of turn
                arm_slot(1);
                expect_quiet();
                apb_read(REG_LBUF2_CTRL, rd, 1'b0);
                check_apb(rd, 32'h1);
                push_lbuf(base[0], wide[0]);
                push_lbuf(base[1], wide[1]);
                load_slot(0, base[0]);
                arm_slot(0);
            end else begin
                push_lbuf(base[0], wide[0]);
                load_slot(0, base[0]);
                arm_slot(0);
                push_lbuf(base[1], wide[1]);  // armed while slot 1 fills
                load_slot(1, base[1]);
                arm_slot(1);
            end
            wait_lbufs(2 * p + 1);
            poll_ctrl_clear(0);
            wait_lbufs(2 * p + 2);
            poll_ctrl_clear(1);
            apb_read(REG_DONE_CNT, rd, 1'b0);
            check_apb(rd, apb_data_t'(16'(lbufs_done)));
        end

        if (lbuf_q.size() != 0 || word_q.size() != 0) begin
            $display("%0d lbufs and %0d stream words never written to memory",
                     lbuf_q.size(), word_q.size());
            abort_run();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim.f
design/rx_lbuf_pkg.sv
design/lbuf_if.sv
design/rx_host_regs.sv
design/rx_gv_lbuf.sv
design/rx_lbuf_writer.sv
design/rx_lbuf_top.sv
testbench/tb_rx_lbuf.sv
